// File: Makefile
TOOL    = verilator
TOP     = icache_tb
FLIST   = flist.f
FLAGS   = --binary --timing --assert -Wno-fatal
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
hw/icache_pkg.sv
hw/icache_ram.sv
hw/icache_cfg.sv
hw/icache_core.sv
hw/icache_top.sv
tests/icache_properties.sv
tests/icache_tb.sv

// File: hw/icache_cfg.sv
`timescale 1ns/10ps

module icache_cfg (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic                             cfg_we_i,
    input  icache_pkg::cfg_addr_e            cfg_addr_i,
    input  logic [icache_pkg::CFG_WIDTH-1:0] cfg_wdata_i,
    output logic [icache_pkg::CFG_WIDTH-1:0] cfg_rdata_o,

    input  logic                             hit_i,
    input  logic                             refill_i,
    output logic                             epoch_o
);

    logic epoch_r;

    // Entry 0 counts hits, entry 1 counts refills
    logic [1:0][icache_pkg::CFG_WIDTH-1:0] cnt;
    logic [1:0]                            cnt_inc;
    logic [1:0]                            cnt_clr;

    assign cnt_inc    = {refill_i, hit_i};
    assign cnt_clr[0] = cfg_we_i && cfg_addr_i == icache_pkg::CFG_HIT_CNT;
    assign cnt_clr[1] = cfg_we_i && cfg_addr_i == icache_pkg::CFG_REFILL_CNT;

    // Flipping the epoch drops every line at once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            epoch_r <= 1'b1;
        end else if (cfg_we_i && cfg_addr_i == icache_pkg::CFG_CTRL && cfg_wdata_i[0]) begin
            epoch_r <= ~epoch_r;
        end
    end

    // Saturating, clear wins over a same-cycle event
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (cnt_clr[i]) begin
                    cnt[i] <= '0;
                end else if (cnt_inc[i] && !(&cnt[i])) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign epoch_o = epoch_r;

    always_comb begin
        case (cfg_addr_i)
            icache_pkg::CFG_CTRL:       cfg_rdata_o = {{(icache_pkg::CFG_WIDTH-1){1'b0}}, epoch_r};
            icache_pkg::CFG_HIT_CNT:    cfg_rdata_o = cnt[0];
            icache_pkg::CFG_REFILL_CNT: cfg_rdata_o = cnt[1];
            default:                    cfg_rdata_o = '0;
        endcase
    end

endmodule

// File: hw/icache_core.sv
`timescale 1ns/10ps

module icache_core #(
    parameter int NSET = 256,
    parameter int NWAY = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              rreq_1_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] raddr_1_i,
    output logic                              rvalid_1_o,
    output logic [icache_pkg::LINE_WIDTH-1:0] rdata_1_o,

    input  logic                              rreq_2_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] raddr_2_i,
    output logic                              rvalid_2_o,
    output logic [icache_pkg::LINE_WIDTH-1:0] rdata_2_o,

    output logic                              mem_rreq_o,
    output logic [icache_pkg::ADDR_WIDTH-1:0] mem_addr_o,
    input  logic                              mem_rdy_i,
    input  logic                              mem_rvalid_i,
    input  logic [icache_pkg::LINE_WIDTH-1:0] mem_data_i,

    input  icache_pkg::fetch_tlb_t            tlb_req_i,
    input  icache_pkg::tlb_resp_t             tlb_i,

    input  logic                              epoch_i,
    output logic                              hit_o,
    output logic                              refill_o
);

    localparam int IDX_W = $clog2(NSET);
    localparam int WAY_W = $clog2(NWAY);
    localparam int PAGE_W = icache_pkg::ADDR_WIDTH - icache_pkg::TAG_WIDTH;

    // Both fetch ports as arrays, index 0 is port 1
    logic [1:0]                                 rreq;
    logic [1:0][icache_pkg::ADDR_WIDTH-1:0]     raddr;
    logic [1:0]                                 rvalid;
    logic [1:0][icache_pkg::LINE_WIDTH-1:0]     rdata;

    assign rreq       = {rreq_2_i, rreq_1_i};
    assign raddr      = {raddr_2_i, raddr_1_i};
    assign rvalid_1_o = rvalid[0];
    assign rvalid_2_o = rvalid[1];
    assign rdata_1_o  = rdata[0];
    assign rdata_2_o  = rdata[1];

    icache_pkg::refill_state_e state, next_state;

    logic [1:0]                             p1_rreq;
    logic [1:0]                             p1_first;
    logic [1:0][icache_pkg::ADDR_WIDTH-1:0] p1_raddr;
    icache_pkg::fetch_tlb_t [1:0]           tlb_req_r;
    icache_pkg::tlb_resp_t [1:0]            tlb_r;

    logic [1:0]                             free;
    logic [1:0]                             need;
    logic [1:0][IDX_W-1:0]                  idx;

    logic [1:0]                             in_req;
    logic [1:0]                             in_wait;
    logic                                   fp;
    logic                                   fill;
    logic                                   filled_r;
    logic [2:0]                             lfsr;
    logic [WAY_W-1:0]                       victim;

    icache_pkg::tag_entry_t [NWAY-1:0][1:0]           tag_rd;
    logic [NWAY-1:0][1:0][icache_pkg::LINE_WIDTH-1:0] data_rd;
    logic [NWAY-1:0][1:0]                             ram_we;
    icache_pkg::tag_entry_t                           fill_entry;

    ////////////////////////////////////////////////////////////
    // P0, RAM index
    ////////////////////////////////////////////////////////////

    // Port can take a new request
    assign free = ~p1_rreq | rvalid;

    // Pending port keeps re-reading its own set
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (free[p]) begin
                idx[p] = raddr[p][icache_pkg::OFFSET_WIDTH +: IDX_W];
            end else begin
                idx[p] = p1_raddr[p][icache_pkg::OFFSET_WIDTH +: IDX_W];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p1_rreq  <= '0;
            p1_first <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (free[p]) begin
                    p1_rreq[p] <= rreq[p];
                end
                p1_first[p] <= free[p] & rreq[p];
            end
        end
    end

    // TLB result is live only in the first P1 cycle
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (free[p]) begin
                p1_raddr[p] <= raddr[p];
            end
            if (p1_first[p]) begin
                tlb_req_r[p] <= tlb_req_i;
                tlb_r[p]     <= tlb_i;
            end
        end
    end

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        icache_ram #(
            .DEPTH(NSET),
            .WIDTH($bits(icache_pkg::tag_entry_t))
        ) u_tag_ram (
            .clk      (clk),
            .we_a_i   (ram_we[w][0]),
            .addr_a_i (idx[0]),
            .wdata_a_i(fill_entry),
            .rdata_a_o(tag_rd[w][0]),
            .we_b_i   (ram_we[w][1]),
            .addr_b_i (idx[1]),
            .wdata_b_i(fill_entry),
            .rdata_b_o(tag_rd[w][1])
        );

        icache_ram #(
            .DEPTH(NSET),
            .WIDTH(icache_pkg::LINE_WIDTH)
        ) u_data_ram (
            .clk      (clk),
            .we_a_i   (ram_we[w][0]),
            .addr_a_i (idx[0]),
            .wdata_a_i(mem_data_i),
            .rdata_a_o(data_rd[w][0]),
            .we_b_i   (ram_we[w][1]),
            .addr_b_i (idx[1]),
            .wdata_b_i(mem_data_i),
            .rdata_b_o(data_rd[w][1])
        );
    end

    ////////////////////////////////////////////////////////////
    // P1, tag compare and line select
    ////////////////////////////////////////////////////////////

    logic [1:0][icache_pkg::TAG_WIDTH-1:0] ptag;
    logic [1:0]                            tlb_miss;
    logic [1:0]                            hit;
    icache_pkg::fetch_tlb_t [1:0]          sel_req;
    icache_pkg::tlb_resp_t [1:0]           sel_tlb;

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            sel_req[p] = p1_first[p] ? tlb_req_i : tlb_req_r[p];
            sel_tlb[p] = p1_first[p] ? tlb_i : tlb_r[p];
            // Translation off means physical equals virtual
            if (sel_req[p].trans_en) begin
                ptag[p] = sel_tlb[p].ptag;
            end else begin
                ptag[p] = p1_raddr[p][icache_pkg::ADDR_WIDTH-1 -: icache_pkg::TAG_WIDTH];
            end
            tlb_miss[p] = p1_rreq[p] & sel_req[p].trans_en & ~sel_tlb[p].found;

            hit[p]   = 1'b0;
            rdata[p] = '0;
            for (int w = 0; w < NWAY; w++) begin
                if (tag_rd[w][p].epoch == epoch_i && tag_rd[w][p].tag == ptag[p]) begin
                    hit[p] = 1'b1;
                    if (!tlb_miss[p]) begin
                        rdata[p] = data_rd[w][p];
                    end
                end
            end
        end
    end

    // No completion while the port's own refill request is open
    assign rvalid = p1_rreq & ~in_req & (tlb_miss | hit);
    assign need   = p1_rreq & ~rvalid;

    // Two hits in one cycle count once
    assign hit_o = |(rvalid & p1_first & ~tlb_miss);

    ////////////////////////////////////////////////////////////
    // Refill
    ////////////////////////////////////////////////////////////

    assign in_req  = {state == icache_pkg::REFILL_2_REQ, state == icache_pkg::REFILL_1_REQ};
    assign in_wait = {state == icache_pkg::REFILL_2_WAIT, state == icache_pkg::REFILL_1_WAIT};

    // Port being refilled, 1 selects fetch port 2
    assign fp = in_req[1] | in_wait[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= icache_pkg::IDLE;
            filled_r <= 1'b0;
        end else begin
            state    <= next_state;
            filled_r <= (|in_wait) & (filled_r | mem_rvalid_i) & (next_state == state);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::IDLE: begin
                if (need[0]) next_state = icache_pkg::REFILL_1_REQ;
                else if (need[1]) next_state = icache_pkg::REFILL_2_REQ;
            end
            icache_pkg::REFILL_1_REQ: begin
                if (mem_rdy_i) next_state = icache_pkg::REFILL_1_WAIT;
            end
            icache_pkg::REFILL_1_WAIT: begin
                if (rvalid[0]) begin
                    next_state = need[1] ? icache_pkg::REFILL_2_REQ : icache_pkg::IDLE;
                end
            end
            icache_pkg::REFILL_2_REQ: begin
                if (mem_rdy_i) next_state = icache_pkg::REFILL_2_WAIT;
            end
            icache_pkg::REFILL_2_WAIT: begin
                if (rvalid[1]) next_state = icache_pkg::IDLE;
            end
            default: begin
                next_state = icache_pkg::IDLE;
            end
        endcase
    end

    assign mem_rreq_o = (|in_req) | ((|in_wait) & ~filled_r & ~mem_rvalid_i);
    assign mem_addr_o = {ptag[fp], p1_raddr[fp][PAGE_W-1:0]};

    // One write per refill, the re-read then completes the port
    assign fill     = (|in_wait) & mem_rvalid_i & ~filled_r;
    assign refill_o = fill;

    // x^3 + x^2 + 1, never zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= 3'b001;
        end else begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    assign victim     = WAY_W'(lfsr % NWAY);
    assign fill_entry = '{epoch: epoch_i, tag: ptag[fp]};

    always_comb begin
        for (int w = 0; w < NWAY; w++) begin
            for (int p = 0; p < 2; p++) begin
                ram_we[w][p] = fill && (victim == WAY_W'(w)) && (fp == 1'(p));
            end
        end
    end

endmodule

// File: hw/icache_pkg.sv
package icache_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Fetch and refill address
    parameter int ADDR_WIDTH = 32;

    // One cache line, also one refill beat
    parameter int LINE_WIDTH = 128;

    // Physical tag, address bits 31:12
    parameter int TAG_WIDTH = 20;

    // Byte offset inside a line, the set index starts above it
    parameter int OFFSET_WIDTH = 4;

    // Configuration bus data
    parameter int CFG_WIDTH = 32;

    ////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////

    // TLB answer for the current fetch
    typedef struct packed {
        logic                 found;
        logic [TAG_WIDTH-1:0] ptag;
    } tlb_resp_t;

    // Translation request from the fetch unit
    typedef struct packed {
        logic trans_en;
    } fetch_tlb_t;

    // One tag RAM word
    typedef struct packed {
        logic                 epoch;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    ////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////

    // Refill machine, port 1 is always served before port 2
    typedef enum logic [2:0] {
        IDLE          = 3'd0,
        REFILL_1_REQ  = 3'd1,
        REFILL_1_WAIT = 3'd2,
        REFILL_2_REQ  = 3'd3,
        REFILL_2_WAIT = 3'd4
    } refill_state_e;

    // Configuration register map
    typedef enum logic [1:0] {
        CFG_CTRL       = 2'd0,
        CFG_HIT_CNT    = 2'd1,
        CFG_REFILL_CNT = 2'd2
    } cfg_addr_e;

endpackage

// File: hw/icache_ram.sv
`timescale 1ns/10ps

module icache_ram #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 128
) (
    input  logic                     clk,

    input  logic                     we_a_i,
    input  logic [$clog2(DEPTH)-1:0] addr_a_i,
    input  logic [WIDTH-1:0]         wdata_a_i,
    output logic [WIDTH-1:0]         rdata_a_o,

    input  logic                     we_b_i,
    input  logic [$clog2(DEPTH)-1:0] addr_b_i,
    input  logic [WIDTH-1:0]         wdata_b_i,
    output logic [WIDTH-1:0]         rdata_b_o
);

    // Power-up contents are all zero
    logic [WIDTH-1:0] mem [DEPTH] = '{default: '0};

    // Read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (we_a_i) begin
            mem[addr_a_i] <= wdata_a_i;
        end
        if (we_b_i) begin
            mem[addr_b_i] <= wdata_b_i;
        end
        rdata_a_o <= mem[addr_a_i];
        rdata_b_o <= mem[addr_b_i];
    end

endmodule

// File: hw/icache_top.sv
`timescale 1ns/10ps

module icache_top #(
    parameter int NSET = 256,
    parameter int NWAY = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              rreq_1_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] raddr_1_i,
    output logic                              rvalid_1_o,
    output logic [icache_pkg::LINE_WIDTH-1:0] rdata_1_o,

    input  logic                              rreq_2_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0] raddr_2_i,
    output logic                              rvalid_2_o,
    output logic [icache_pkg::LINE_WIDTH-1:0] rdata_2_o,

    output logic                              mem_rreq_o,
    output logic [icache_pkg::ADDR_WIDTH-1:0] mem_addr_o,
    input  logic                              mem_rdy_i,
    input  logic                              mem_rvalid_i,
    input  logic [icache_pkg::LINE_WIDTH-1:0] mem_data_i,

    input  icache_pkg::fetch_tlb_t            tlb_req_i,
    input  icache_pkg::tlb_resp_t             tlb_i,

    input  logic                              cfg_we_i,
    input  icache_pkg::cfg_addr_e             cfg_addr_i,
    input  logic [icache_pkg::CFG_WIDTH-1:0]  cfg_wdata_i,
    output logic [icache_pkg::CFG_WIDTH-1:0]  cfg_rdata_o
);

    logic epoch;
    logic hit;
    logic refill;

    icache_cfg u_cfg (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_we_i   (cfg_we_i),
        .cfg_addr_i (cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i),
        .cfg_rdata_o(cfg_rdata_o),
        .hit_i      (hit),
        .refill_i   (refill),
        .epoch_o    (epoch)
    );

    icache_core #(
        .NSET(NSET),
        .NWAY(NWAY)
    ) u_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .rreq_1_i    (rreq_1_i),
        .raddr_1_i   (raddr_1_i),
        .rvalid_1_o  (rvalid_1_o),
        .rdata_1_o   (rdata_1_o),
        .rreq_2_i    (rreq_2_i),
        .raddr_2_i   (raddr_2_i),
        .rvalid_2_o  (rvalid_2_o),
        .rdata_2_o   (rdata_2_o),
        .mem_rreq_o  (mem_rreq_o),
        .mem_addr_o  (mem_addr_o),
        .mem_rdy_i   (mem_rdy_i),
        .mem_rvalid_i(mem_rvalid_i),
        .mem_data_i  (mem_data_i),
        .tlb_req_i   (tlb_req_i),
        .tlb_i       (tlb_i),
        .epoch_i     (epoch),
        .hit_o       (hit),
        .refill_o    (refill)
    );

endmodule

// File: tests/icache_properties.sv
`timescale 1ns/10ps

module icache_properties (
    input logic                              clk,
    input logic                              rst_n,
    input icache_pkg::refill_state_e         state_i,
    input logic                              mem_rreq_i,
    input logic [icache_pkg::ADDR_WIDTH-1:0] mem_addr_i,
    input logic                              mem_rvalid_i,
    input logic                              rvalid_1_i,
    input logic                              rvalid_2_i
);

    // Open refill request holds until the line arrives
    rreq_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rreq_i && !mem_rvalid_i |=> mem_rreq_i || mem_rvalid_i)
        else $error("refill request dropped before the line arrived");

    // Refill address stays put while the request is open
    addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rreq_i && $past(mem_rreq_i) |-> $stable(mem_addr_i))
        else $error("refill address changed during an open request");

    // A port cannot complete while its own refill request is open
    req_1_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rreq_i
        && state_i inside {icache_pkg::REFILL_1_REQ, icache_pkg::REFILL_1_WAIT}
        |-> !rvalid_1_i)
        else $error("port 1 completed before its refill line arrived");

    req_2_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rreq_i
        && state_i inside {icache_pkg::REFILL_2_REQ, icache_pkg::REFILL_2_WAIT}
        |-> !rvalid_2_i)
        else $error("port 2 completed before its refill line arrived");

endmodule

bind icache_core icache_properties u_properties (
    .clk         (clk),
    .rst_n       (rst_n),
    .state_i     (state),
    .mem_rreq_i  (mem_rreq_o),
    .mem_addr_i  (mem_addr_o),
    .mem_rvalid_i(mem_rvalid_i),
    .rvalid_1_i  (rvalid_1_o),
    .rvalid_2_i  (rvalid_2_o)
);

// File: tests/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

    localparam int NSET    = 256;
    localparam int NWAY    = 2;
    localparam int TIMEOUT = 200;
    localparam int NTEST   = 20;

    // XOR key of the memory model line
    localparam logic [31:0] LINE_KEY = 32'h5a5a_c3c3;

    typedef enum logic [2:0] {
        OP_FETCH1,
        OP_FETCH2,
        OP_FETCH_BOTH,
        OP_INVAL,
        OP_READ,
        OP_CLEAR
    } op_e;

    typedef struct packed {
        op_e                               op;
        logic [icache_pkg::ADDR_WIDTH-1:0] addr_1;
        logic [icache_pkg::ADDR_WIDTH-1:0] addr_2;
        logic                              trans_en;
        logic                              found;
        logic [icache_pkg::TAG_WIDTH-1:0]  ptag;
        logic                              exp_hit;
        icache_pkg::cfg_addr_e             reg_sel;
        logic [icache_pkg::CFG_WIDTH-1:0]  exp_val;
    } test_row_t;

    logic                              clk;
    logic                              rst_n;
    logic                              rreq_1;
    logic                              rreq_2;
    logic [icache_pkg::ADDR_WIDTH-1:0] raddr_1;
    logic [icache_pkg::ADDR_WIDTH-1:0] raddr_2;
    logic                              rvalid_1;
    logic                              rvalid_2;
    logic [icache_pkg::LINE_WIDTH-1:0] rdata_1;
    logic [icache_pkg::LINE_WIDTH-1:0] rdata_2;
    logic                              mem_rreq;
    logic [icache_pkg::ADDR_WIDTH-1:0] mem_addr;
    logic                              mem_rdy;
    logic                              mem_rvalid;
    logic [icache_pkg::LINE_WIDTH-1:0] mem_data;
    icache_pkg::fetch_tlb_t            tlb_req;
    icache_pkg::tlb_resp_t             tlb;
    logic                              cfg_we;
    icache_pkg::cfg_addr_e             cfg_addr;
    logic [icache_pkg::CFG_WIDTH-1:0]  cfg_wdata;
    logic [icache_pkg::CFG_WIDTH-1:0]  cfg_rdata;

    logic [icache_pkg::ADDR_WIDTH-1:0] refill_q [$];
    int                                err_count;
    int                                check_total;
    int                                tests_run;
    int                                cur_test;
    logic                              timed_out;

    // Sets are all distinct except where a line is refetched on purpose
    test_row_t stim [NTEST] = '{
        '{OP_FETCH1, 32'h0001_2340, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_CTRL, 32'd0},
        '{OP_FETCH1, 32'h0001_2340, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b1, icache_pkg::CFG_CTRL, 32'd0},
        '{OP_FETCH2, 32'h0, 32'h0001_2340, 1'b0, 1'b0, 20'h0,
          1'b1, icache_pkg::CFG_CTRL, 32'd0},
        // Translated fetch
        '{OP_FETCH1, 32'h7777_7560, 32'h0, 1'b1, 1'b1, 20'habcde,
          1'b0, icache_pkg::CFG_CTRL, 32'd0},
        '{OP_FETCH1, 32'h7777_7560, 32'h0, 1'b1, 1'b1, 20'habcde,
          1'b1, icache_pkg::CFG_CTRL, 32'd0},
        '{OP_FETCH_BOTH, 32'h0002_4780, 32'h0003_69a0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_CTRL, 32'd0},
        '{OP_FETCH_BOTH, 32'h0002_4780, 32'h0003_69a0, 1'b0, 1'b0, 20'h0,
          1'b1, icache_pkg::CFG_CTRL, 32'd0},
        // TLB miss, done at once with zero data
        '{OP_FETCH1, 32'h0004_8bc0, 32'h0, 1'b1, 1'b0, 20'h0,
          1'b1, icache_pkg::CFG_CTRL, 32'd0},
        '{OP_READ, 32'h0, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_HIT_CNT, 32'd4},
        '{OP_READ, 32'h0, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_REFILL_CNT, 32'd4},
        '{OP_INVAL, 32'h0, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_CTRL, 32'd0},
        '{OP_READ, 32'h0, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_CTRL, 32'd0},
        '{OP_FETCH1, 32'h0001_2340, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_CTRL, 32'd0},
        '{OP_FETCH1, 32'h0001_2340, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b1, icache_pkg::CFG_CTRL, 32'd0},
        '{OP_READ, 32'h0, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_HIT_CNT, 32'd5},
        '{OP_READ, 32'h0, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_REFILL_CNT, 32'd5},
        '{OP_CLEAR, 32'h0, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_HIT_CNT, 32'd0},
        '{OP_READ, 32'h0, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_HIT_CNT, 32'd0},
        '{OP_CLEAR, 32'h0, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_REFILL_CNT, 32'd0},
        '{OP_READ, 32'h0, 32'h0, 1'b0, 1'b0, 20'h0,
          1'b0, icache_pkg::CFG_REFILL_CNT, 32'd0}
    };

    icache_top #(
        .NSET(NSET),
        .NWAY(NWAY)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .rreq_1_i    (rreq_1),
        .raddr_1_i   (raddr_1),
        .rvalid_1_o  (rvalid_1),
        .rdata_1_o   (rdata_1),
        .rreq_2_i    (rreq_2),
        .raddr_2_i   (raddr_2),
        .rvalid_2_o  (rvalid_2),
        .rdata_2_o   (rdata_2),
        .mem_rreq_o  (mem_rreq),
        .mem_addr_o  (mem_addr),
        .mem_rdy_i   (mem_rdy),
        .mem_rvalid_i(mem_rvalid),
        .mem_data_i  (mem_data),
        .tlb_req_i   (tlb_req),
        .tlb_i       (tlb),
        .cfg_we_i    (cfg_we),
        .cfg_addr_i  (cfg_addr),
        .cfg_wdata_i (cfg_wdata),
        .cfg_rdata_o (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////////////////////////

    function automatic logic [icache_pkg::LINE_WIDTH-1:0] line_for(
        input logic [icache_pkg::ADDR_WIDTH-1:0] addr
    );
        return {4{addr ^ LINE_KEY}};
    endfunction

    function automatic logic [icache_pkg::ADDR_WIDTH-1:0] phys_addr(
        input test_row_t row,
        input logic [icache_pkg::ADDR_WIDTH-1:0] va
    );
        if (row.trans_en) begin
            return {row.ptag, va[11:0]};
        end
        return va;
    endfunction

    function automatic logic [icache_pkg::LINE_WIDTH-1:0] expected_line(
        input test_row_t row,
        input logic [icache_pkg::ADDR_WIDTH-1:0] va
    );
        if (row.trans_en && !row.found) begin
            return '0;
        end
        return line_for(phys_addr(row, va));
    endfunction

    function automatic string op_name(input op_e op);
        case (op)
            OP_FETCH1:     return "fetch port 1";
            OP_FETCH2:     return "fetch port 2";
            OP_FETCH_BOTH: return "fetch both";
            OP_INVAL:      return "invalidate";
            OP_READ:       return "counter read";
            default:       return "counter clear";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_line(input string what,
                              input logic [icache_pkg::LINE_WIDTH-1:0] got,
                              input logic [icache_pkg::LINE_WIDTH-1:0] exp);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch at %0t: test %0d %s, got %h, expected %h",
                     $time, cur_test, what, got, exp);
        end
    endtask

    task automatic check_cfg(input string what,
                             input logic [icache_pkg::CFG_WIDTH-1:0] got,
                             input logic [icache_pkg::CFG_WIDTH-1:0] exp);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch at %0t: test %0d %s, got %0d, expected %0d",
                     $time, cur_test, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what,
                              input logic [icache_pkg::ADDR_WIDTH-1:0] got,
                              input logic [icache_pkg::ADDR_WIDTH-1:0] exp);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch at %0t: test %0d %s, got %h, expected %h",
                     $time, cur_test, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch at %0t: test %0d %s, got %b, expected %b",
                     $time, cur_test, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        check_total++;
        if (got != exp) begin
            err_count++;
            $display("Mismatch at %0t: test %0d %s, got %0d, expected %0d",
                     $time, cur_test, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////

    initial begin : mem_model
        logic [icache_pkg::ADDR_WIDTH-1:0] addr;
        int unsigned                       delay;
        void'($urandom(32'hc846a0f7));
        mem_rdy    = 1'b0;
        mem_rvalid = 1'b0;
        mem_data   = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_rreq) begin
                addr = mem_addr;
                refill_q.push_back(addr);
                delay = $urandom % 4;
                repeat (delay) @(negedge clk);
                mem_rdy = 1'b1;
                @(negedge clk);
                mem_rdy = 1'b0;
                delay = $urandom % 4;
                repeat (delay) @(negedge clk);
                mem_rvalid = 1'b1;
                mem_data   = line_for(addr);
                @(negedge clk);
                mem_rvalid = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Operations
    ////////////////////////////////////////////////////////////

    task automatic run_fetch(input test_row_t row);
        logic                              use_1;
        logic                              use_2;
        logic                              done_1;
        logic                              done_2;
        int                                cycles;
        int                                cyc_1;
        int                                cyc_2;
        logic [icache_pkg::LINE_WIDTH-1:0] line_1;
        logic [icache_pkg::LINE_WIDTH-1:0] line_2;
        logic [icache_pkg::ADDR_WIDTH-1:0] exp_q [$];
        use_1  = row.op != OP_FETCH2;
        use_2  = row.op != OP_FETCH1;
        done_1 = !use_1;
        done_2 = !use_2;
        cycles = 0;
        cyc_1  = 0;
        cyc_2  = 0;
        refill_q.delete();
        tlb_req.trans_en = row.trans_en;
        tlb.found        = row.found;
        tlb.ptag         = row.ptag;
        raddr_1 = row.addr_1;
        raddr_2 = row.addr_2;
        rreq_1  = use_1;
        rreq_2  = use_2;
        while (!(done_1 && done_2) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (!done_1 && rvalid_1) begin
                done_1 = 1'b1;
                cyc_1  = cycles;
                line_1 = rdata_1;
                rreq_1 = 1'b0;
            end
            if (!done_2 && rvalid_2) begin
                done_2 = 1'b1;
                cyc_2  = cycles;
                line_2 = rdata_2;
                rreq_2 = 1'b0;
            end
        end
        if (!(done_1 && done_2)) begin
            $display("Timeout: no rvalid within %0d cycles in test %0d", TIMEOUT, cur_test);
            timed_out = 1'b1;
            return;
        end
        // Let the completing edge pass with the TLB inputs unchanged
        @(negedge clk);
        if (!row.exp_hit && use_1) exp_q.push_back(phys_addr(row, row.addr_1));
        if (!row.exp_hit && use_2) exp_q.push_back(phys_addr(row, row.addr_2));
        check_count("refill requests", refill_q.size(), exp_q.size());
        for (int k = 0; k < refill_q.size() && k < exp_q.size(); k++) begin
            check_addr("refill address", refill_q[k], exp_q[k]);
        end
        if (use_1) begin
            check_flag("port 1 done at t+1", cyc_1 == 1, row.exp_hit);
            check_line("port 1 line", line_1, expected_line(row, row.addr_1));
        end
        if (use_2) begin
            check_flag("port 2 done at t+1", cyc_2 == 1, row.exp_hit);
            check_line("port 2 line", line_2, expected_line(row, row.addr_2));
        end
        if (use_1 && use_2 && !row.exp_hit) begin
            check_flag("port 1 before port 2", cyc_1 < cyc_2, 1'b1);
        end
    endtask

    task automatic run_inval();
        cfg_addr  = icache_pkg::CFG_CTRL;
        cfg_wdata = 32'h1;
        cfg_we    = 1'b1;
        @(negedge clk);
        cfg_we    = 1'b0;
        cfg_wdata = '0;
    endtask

    task automatic run_read(input test_row_t row);
        cfg_addr = row.reg_sel;
        @(negedge clk);
        check_cfg("register read", cfg_rdata, row.exp_val);
    endtask

    task automatic run_clear(input test_row_t row);
        cfg_addr  = row.reg_sel;
        cfg_wdata = '0;
        cfg_we    = 1'b1;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    initial begin : main
        int errs_before;
        rst_n     = 1'b0;
        rreq_1    = 1'b0;
        rreq_2    = 1'b0;
        raddr_1   = '0;
        raddr_2   = '0;
        tlb_req   = '0;
        tlb       = '0;
        cfg_we    = 1'b0;
        cfg_addr  = icache_pkg::CFG_CTRL;
        cfg_wdata = '0;
        err_count   = 0;
        check_total = 0;
        tests_run   = 0;
        timed_out   = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < NTEST; i++) begin
            cur_test    = i;
            errs_before = err_count;
            case (stim[i].op)
                OP_FETCH1, OP_FETCH2, OP_FETCH_BOTH: run_fetch(stim[i]);
                OP_INVAL: run_inval();
                OP_READ:  run_read(stim[i]);
                default:  run_clear(stim[i]);
            endcase
            tests_run++;
            $display("test %0d %s: %s", i, op_name(stim[i].op),
                     (err_count == errs_before && !timed_out) ? "ok" : "FAILED");
            if (timed_out) break;
        end
        $display("Tests run %0d, checks %0d, mismatches %0d", tests_run, check_total, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
